/* run_sim.sh */
#!/usr/bin/env bash
# build and run the DMA path testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim_run.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_dma_path \
	-f vlog.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_dma_path > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" "$log"; then
	exit 1
fi
exit 0

/* sim/dma_path_stim.svh */
/*
 * Burst table for the DMA path testbench, included inside the testbench module.
 * Entries of one group request at the same time. ord is the expected grant
 * order over the whole run; read and write outputs follow it per stream.
 * Forms other than read and write must produce no command.
 */
`ifndef DMA_PATH_STIM_SVH
`define DMA_PATH_STIM_SVH

localparam int num_entries = 12;
localparam int num_groups = 6;

typedef struct {
	int group;
	int port;
	logic [7:0] form;
	logic [15:0] len;        // data words for a write, read length for a read
	logic [39:0] dram;
	logic [15:0] dpram;
	logic [31:0] base;       // first data word value
	int ord;
} stim_t;

stim_t tbl [num_entries];

// group, port, form, length, dram address, dpram address, data base, grant order
task automatic load_table();
	tbl[0]  = '{0, 1, 8'h01, 16'd8,  40'h01_0000_0100, 16'hf010, 32'h0000_0000, 0};
	tbl[1]  = '{1, 2, 8'h03, 16'd3,  40'h02_0000_0200, 16'h3020, 32'h2000_0000, 1};
	tbl[2]  = '{2, 0, 8'h01, 16'd4,  40'h03_0000_0300, 16'h1030, 32'h0000_0000, 3};
	tbl[3]  = '{2, 1, 8'h03, 16'd2,  40'h04_0000_0400, 16'hc040, 32'h4000_0000, 4};
	tbl[4]  = '{2, 2, 8'h01, 16'd16, 40'h05_0000_0500, 16'h7050, 32'h0000_0000, 5};
	tbl[5]  = '{2, 3, 8'h03, 16'd4,  40'h06_0000_0600, 16'h9060, 32'h6000_0000, 2};
	tbl[6]  = '{3, 0, 8'h05, 16'd2,  40'h07_0000_0700, 16'h5070, 32'h7000_0000, 6};
	tbl[7]  = '{3, 1, 8'h01, 16'd1,  40'h08_0000_0800, 16'hb080, 32'h0000_0000, 7};
	tbl[8]  = '{4, 2, 8'h01, 16'd32, 40'h09_0000_0900, 16'he090, 32'h0000_0000, 8};
	tbl[9]  = '{4, 3, 8'h03, 16'd1,  40'h0a_0000_0a00, 16'h20a0, 32'ha000_0000, 9};
	tbl[10] = '{5, 0, 8'h00, 16'd0,  40'h0b_0000_0b00, 16'h40b0, 32'h0000_0000, 10};
	tbl[11] = '{5, 3, 8'h03, 16'd5,  40'h0c_0000_0c00, 16'hd0c0, 32'hc000_0000, 11};
endtask

`endif

/* sim/tb_dma_path.sv */
/*
 * Testbench for the DMA path controller.
 * Port drivers send the bursts of the stimulus table group by group; monitors
 * check grant order, rcc commands and wcc words against expected queues built
 * from the table. rcc_ready and wcc_ready drop at random (seed 44).
 */
`timescale 1ns/100ps
`include "dma_path_cfg.svh"

module tb_dma_path;

	import dma_hdr_pkg::*;
	import dma_port_pkg::*;

	logic fpu_clk;
	logic reset;
	port_vec_t dma_req;
	port_vec_t dma_resp;
	port_vec_t dma_write_valid;
	port_vec_t dma_write_ready;
	dma_word_t dma_write_data [`DMA_NUM_PORTS];
	logic rcc_valid;
	logic rcc_ready;
	logic [`DMA_DRAM_ADDR_W-1:0] rcc_dram_addr;
	logic [`DMA_DPRAM_ADDR_W-1:0] rcc_dpram_addr;
	logic [`DMA_LEN_W-1:0] rcc_length;
	logic wcc_valid;
	logic wcc_ready;
	logic [`DMA_DRAM_ADDR_W-1:0] wcc_dram_addr;
	logic [`DMA_DPRAM_ADDR_W-1:0] wcc_dpram_addr;
	logic [`DMA_LEN_W-1:0] wcc_length;
	dma_word_t wcc_write_data;

	`include "dma_path_stim.svh"

	int errors = 0;
	int reads_seen = 0;
	int words_seen = 0;
	int grants_seen = 0;
	int rd_exp [$];     // table indices in expected output order
	int wr_exp [$];
	int grant_exp [$];  // port ids in expected grant order
	int wr_cnt = 0;
	int re;
	int we;
	int gp;
	port_vec_t resp_q;

	dma_path_top uut (.*);

	always #10 fpu_clk = ~fpu_clk;

	////////////////////////////////////////////////////////////////////
	// helpers

	task automatic mismatch(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		errors++;
		$display("Error: %s got %0h expected %0h", name, got, exp);
	endtask

	task automatic fault(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	task automatic summary_line();
		$display("grants %0d, read commands %0d, write words %0d, errors %0d",
			grants_seen, reads_seen, words_seen, errors);
	endtask

	function automatic dma_word_t header_word(input int idx);
		dma_word_t w;
		w = '0;
		w[`DMA_FORM_HI:`DMA_FORM_LO] = tbl[idx].form;
		w[`DMA_LEN_LO +: `DMA_LEN_W] = tbl[idx].len;
		w[`DMA_DRAM_LO +: `DMA_DRAM_ADDR_W] = tbl[idx].dram;
		w[`DMA_DPRAM_ADDR_W-1:0] = tbl[idx].dpram;
		return w;
	endfunction

	function automatic dma_word_t data_word(input int idx, input int k);
		return {4{tbl[idx].base + 32'(k)}};
	endfunction

	// port id on 15:14, 13:12 cleared
	function automatic logic [15:0] exp_dpram(input int idx);
		return {2'(tbl[idx].port), 2'b00, tbl[idx].dpram[11:0]};
	endfunction

	// request, header, then data words of one burst on one port
	task automatic send_burst(input int idx);
		int p;
		int nwords;
		int k;
		p = tbl[idx].port;
		nwords = (tbl[idx].form == `DMA_FORM_READ) ? 0 : int'(tbl[idx].len);
		dma_req[p] = 1'b1;
		do @(posedge fpu_clk); while (!dma_resp[p]);
		#2;
		dma_write_data[p] = header_word(idx);
		dma_write_valid[p] = 1'b1;
		k = 0;      // header is word 0
		while (k <= nwords) begin
			@(posedge fpu_clk);
			if (dma_write_ready[p]) k++;
			#2;
			if (k > 0 && k <= nwords) dma_write_data[p] = data_word(idx, k - 1);
		end
		dma_req[p] = 1'b0;
		dma_write_valid[p] = 1'b0;
	endtask

	task automatic run_port(input int p, input int g);
		for (int i = 0; i < num_entries; i++) begin
			if (tbl[i].group == g && tbl[i].port == p) send_burst(i);
		end
	endtask

	////////////////////////////////////////////////////////////////////
	// monitors

	always @(posedge fpu_clk) begin
		if (!reset) begin
			assert ((dma_resp & ~dma_req) == '0)
				else fault("dma_resp raised for a port that is not requesting");
			assert ($countones(dma_resp) <= 1) else fault("dma_resp raised on several ports");
			assert ($countones(dma_write_ready) <= 1)
				else fault("dma_write_ready raised on several ports");
			if (dma_resp != '0 && resp_q == '0) begin   // new grant
				grants_seen++;
				assert (grant_exp.size() != 0) else fault("grant seen with no burst pending");
				if (grant_exp.size() != 0) begin
					gp = grant_exp.pop_front();
					assert (dma_resp == (port_vec_t'(1) << gp))
						else mismatch("dma_resp", dma_resp, port_vec_t'(1) << gp);
				end
			end
			resp_q = dma_resp;
		end
	end

	always @(posedge fpu_clk) begin
		if (!reset && rcc_valid && rcc_ready) begin
			reads_seen++;
			assert (rd_exp.size() != 0) else fault("read command issued with none expected");
			if (rd_exp.size() != 0) begin
				re = rd_exp.pop_front();
				assert (rcc_length == tbl[re].len)
					else mismatch("rcc_length", rcc_length, tbl[re].len);
				assert (rcc_dram_addr == tbl[re].dram)
					else mismatch("rcc_dram_addr", rcc_dram_addr, tbl[re].dram);
				assert (rcc_dpram_addr == exp_dpram(re))
					else mismatch("rcc_dpram_addr", rcc_dpram_addr, exp_dpram(re));
			end
		end
	end

	always @(posedge fpu_clk) begin
		if (!reset && wcc_valid && wcc_ready) begin
			words_seen++;
			assert (wr_exp.size() != 0) else fault("write data word issued with none expected");
			if (wr_exp.size() != 0) begin
				we = wr_exp[0];
				assert (wcc_length == tbl[we].len)
					else mismatch("wcc_length", wcc_length, tbl[we].len);
				assert (wcc_dram_addr == tbl[we].dram)
					else mismatch("wcc_dram_addr", wcc_dram_addr, tbl[we].dram);
				assert (wcc_dpram_addr == exp_dpram(we))
					else mismatch("wcc_dpram_addr", wcc_dpram_addr, exp_dpram(we));
				assert (wcc_write_data == data_word(we, wr_cnt))
					else mismatch("wcc_write_data", wcc_write_data, data_word(we, wr_cnt));
				wr_cnt++;
				if (wr_cnt == int'(tbl[we].len)) begin   // burst complete
					void'(wr_exp.pop_front());
					wr_cnt = 0;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////
	// stimulus

	initial begin
		fpu_clk = 1'b0;
		reset = 1'b1;
		dma_req = '0;
		dma_write_valid = '0;
		for (int i = 0; i < `DMA_NUM_PORTS; i++) dma_write_data[i] = '0;
		rcc_ready = 1'b0;
		wcc_ready = 1'b0;
		resp_q = '0;
		load_table();
		for (int o = 0; o < num_entries; o++) begin
			for (int i = 0; i < num_entries; i++) begin
				if (tbl[i].ord == o) begin
					grant_exp.push_back(tbl[i].port);
					if (tbl[i].form == `DMA_FORM_READ) rd_exp.push_back(i);
					else if (tbl[i].form == `DMA_FORM_WRITE) wr_exp.push_back(i);
				end
			end
		end

		repeat (8) @(posedge fpu_clk);
		#2 reset = 1'b0;
		repeat (2) @(posedge fpu_clk);
		assert (dma_resp == '0) else mismatch("dma_resp", dma_resp, 0);
		assert (dma_write_ready == '0) else mismatch("dma_write_ready", dma_write_ready, 0);
		assert (rcc_valid == 1'b0) else mismatch("rcc_valid", rcc_valid, 0);
		assert (wcc_valid == 1'b0) else mismatch("wcc_valid", wcc_valid, 0);
		#2;

		for (int g = 0; g < num_groups; g++) begin
			fork
				run_port(0, g);
				run_port(1, g);
				run_port(2, g);
				run_port(3, g);
			join
		end

		while (rd_exp.size() != 0 || wr_exp.size() != 0) @(posedge fpu_clk);
		repeat (10) @(posedge fpu_clk);   // catch stray commands
		assert (grant_exp.size() == 0) else fault("some bursts were never granted");
		assert (rcc_valid == 1'b0) else mismatch("rcc_valid", rcc_valid, 0);
		assert (wcc_valid == 1'b0) else mismatch("wcc_valid", wcc_valid, 0);

		summary_line();
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// random low periods on both ready inputs
	initial begin
		void'($urandom(44));
		@(negedge reset);
		forever begin
			@(posedge fpu_clk);
			#2;
			rcc_ready = (($urandom % 4) != 0);
			wcc_ready = (($urandom % 4) != 0);
		end
	end

	initial begin
		repeat (num_entries * 400) @(posedge fpu_clk);
		$display("timeout: expected commands or data words never came out");
		summary_line();
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* verilog/burst_receiver.sv */
/*
 * Takes the header and data words of the granted port into the burst FIFO.
 * A read header is the whole burst; any other form is followed by as many data
 * words as its length field says. burst_full stalls the port through ready.
 * burst_done pulses one cycle after the last word is taken.
 */
`timescale 1ns/100ps
`include "dma_path_cfg.svh"

module burst_receiver (
	input  logic fpu_clk,
	input  logic reset,
	input  dma_port_pkg::port_vec_t grant,
	input  dma_port_pkg::port_vec_t dma_write_valid,
	input  dma_hdr_pkg::dma_word_t dma_write_data [`DMA_NUM_PORTS],
	output dma_port_pkg::port_vec_t dma_resp,
	output dma_port_pkg::port_vec_t dma_write_ready,
	input  logic burst_full,
	output logic burst_push,
	output dma_hdr_pkg::dma_word_t burst_word,
	output logic burst_done
);

	import dma_hdr_pkg::*;

	typedef enum logic [1:0] {st_idle, st_hdr, st_data, st_done} rx_state_t;

	rx_state_t state;
	dma_len_t len;          // data words after the header
	dma_len_t cnt;
	msg_form_t hdr_form;
	dma_len_t hdr_len;
	logic sel_valid;
	logic ready;

	// granted port's word and valid
	always_comb begin
		burst_word = '0;
		for (int i = 0; i < `DMA_NUM_PORTS; i++) begin
			if (grant[i]) burst_word = dma_write_data[i];
		end
	end

	assign sel_valid = |(dma_write_valid & grant);
	assign ready = ((state == st_hdr) || (state == st_data)) && !burst_full;
	assign burst_push = sel_valid && ready;
	assign dma_write_ready = ready ? grant : '0;
	assign dma_resp = (state == st_hdr) ? grant : '0;
	assign burst_done = (state == st_done);

	assign hdr_form = burst_word[`DMA_FORM_HI:`DMA_FORM_LO];
	assign hdr_len = burst_word[`DMA_LEN_LO +: `DMA_LEN_W];

	always_ff @(posedge fpu_clk) begin
		if (burst_push && state == st_hdr) len <= hdr_len;
	end

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			state <= st_idle;
			cnt <= '0;
		end else begin
			case (state)
				st_idle: if (|grant) state <= st_hdr;
				st_hdr: begin
					if (burst_push) begin
						cnt <= '0;
						if (hdr_form == `DMA_FORM_READ || hdr_len == '0) state <= st_done;
						else state <= st_data;
					end
				end
				st_data: begin
					if (burst_push) begin
						cnt <= cnt + dma_len_t'(1);
						if (cnt + dma_len_t'(1) == len) state <= st_done;
					end
				end
				default: state <= st_idle;   // grant drops on the same edge
			endcase
		end
	end

endmodule

/* verilog/cmd_dispatcher.sv */
/*
 * Turns burst headers into read or write commands.
 * A header is taken only once its port tag is queued, so the whole burst is
 * already in the burst FIFO. The port id goes into DPRAM address bits 15:14
 * and bits 13:12 are cleared. Headers of other forms are dropped along with
 * their data words. Write data goes on the burst FIFO head, wired in the top.
 */
`timescale 1ns/100ps
`include "dma_path_cfg.svh"

module cmd_dispatcher (
	input  logic fpu_clk,
	input  logic reset,
	input  logic burst_empty,
	input  dma_hdr_pkg::dma_word_t burst_word,
	output logic burst_pop,
	input  logic tag_empty,
	input  dma_port_pkg::port_id_t tag_id,
	output logic tag_pop,
	input  logic rcmd_full,
	output logic rcmd_push,
	input  logic wcmd_full,
	output logic wcmd_push,
	output dma_hdr_pkg::dma_cmd_t cmd,
	input  logic wdata_full,
	output logic wdata_push
);

	import dma_hdr_pkg::*;

	typedef enum logic [2:0] {
		st_idle, st_decode, st_rpush, st_wpush, st_move, st_skip
	} disp_state_t;

	disp_state_t state;
	msg_form_t form;
	dma_len_t cnt;          // data words moved or skipped
	logic hdr_take;

	assign hdr_take = (state == st_idle) && !burst_empty && !tag_empty;
	assign tag_pop = hdr_take;
	assign wdata_push = (state == st_move) && !burst_empty && !wdata_full;
	assign burst_pop = hdr_take || wdata_push || ((state == st_skip) && !burst_empty);
	assign rcmd_push = (state == st_rpush) && !rcmd_full;
	assign wcmd_push = (state == st_wpush) && !wcmd_full;

	always_ff @(posedge fpu_clk) begin
		if (hdr_take) begin
			form <= burst_word[`DMA_FORM_HI:`DMA_FORM_LO];
			cmd.length <= burst_word[`DMA_LEN_LO +: `DMA_LEN_W];
			cmd.dram_addr <= burst_word[`DMA_DRAM_LO +: `DMA_DRAM_ADDR_W];
			cmd.dpram_addr <= {tag_id, 2'b00, burst_word[`DMA_DPRAM_ADDR_W-5:0]};
		end
	end

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			state <= st_idle;
			cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					cnt <= '0;
					if (hdr_take) state <= st_decode;
				end
				st_decode: begin
					if (form == `DMA_FORM_READ) state <= st_rpush;
					else if (form == `DMA_FORM_WRITE) state <= st_wpush;
					else if (cmd.length == '0) state <= st_idle;
					else state <= st_skip;       // drain the data of an unknown form
				end
				st_rpush: if (rcmd_push) state <= st_idle;
				st_wpush: begin
					if (wcmd_push) state <= (cmd.length == '0) ? st_idle : st_move;
				end
				st_move, st_skip: begin
					if (burst_pop) begin
						cnt <= cnt + dma_len_t'(1);
						if (cnt + dma_len_t'(1) == cmd.length) state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

/* verilog/dma_hdr_pkg.sv */
/*
 * Header and command types of the DMA path.
 * dma_cmd_t keeps the header bit order, so length sits on top and the DPRAM
 * address at the bottom of the 72-bit command.
 */
`include "dma_path_cfg.svh"

package dma_hdr_pkg;

	typedef logic [`DMA_WORD_W-1:0] dma_word_t;                      // header or data
	typedef logic [`DMA_FORM_HI-`DMA_FORM_LO:0] msg_form_t;
	typedef logic [`DMA_LEN_W-1:0] dma_len_t;

	// one command as stored in the read and write command FIFOs
	typedef struct packed {
		dma_len_t length;                           // data words after the header
		logic [`DMA_DRAM_ADDR_W-1:0] dram_addr;
		logic [`DMA_DPRAM_ADDR_W-1:0] dpram_addr;   // port id in 15:14
	} dma_cmd_t;

endpackage

/* verilog/dma_path_cfg.svh */
/*
 * Widths, header bit positions, message codes and FIFO depths of the DMA path.
 * A header word carries form, length and both addresses at the positions below.
 * FIFO depths must be powers of two no smaller than 2.
 */
`ifndef DMA_PATH_CFG_SVH
`define DMA_PATH_CFG_SVH

`define DMA_WORD_W        128
`define DMA_DRAM_ADDR_W   40
`define DMA_DPRAM_ADDR_W  16
`define DMA_LEN_W         16
`define DMA_NUM_PORTS     4

// header layout
`define DMA_FORM_LO       72
`define DMA_FORM_HI       79
`define DMA_LEN_LO        56     // length in 71:56
`define DMA_DRAM_LO       16     // dram address in 55:16

`define DMA_FORM_READ     8'h01
`define DMA_FORM_WRITE    8'h03

`define DMA_BURST_DEPTH   256
`define DMA_WDATA_DEPTH   256
`define DMA_CMD_DEPTH     32
`define DMA_TAG_DEPTH     256

`endif

/* verilog/dma_path_top.sv */
/*
 * DMA path controller, single clock fpu_clk.
 * Port bursts are arbitrated round robin, queued, split into read and write
 * commands and sent out. The read-return path is not part of this block.
 * rcc_valid shows a waiting read command regardless of rcc_ready.
 */
`timescale 1ns/100ps
`include "dma_path_cfg.svh"

module dma_path_top (
	input  logic fpu_clk,
	input  logic reset,
	input  dma_port_pkg::port_vec_t dma_req,
	output dma_port_pkg::port_vec_t dma_resp,
	input  dma_port_pkg::port_vec_t dma_write_valid,
	input  dma_hdr_pkg::dma_word_t dma_write_data [`DMA_NUM_PORTS],
	output dma_port_pkg::port_vec_t dma_write_ready,
	output logic rcc_valid,
	input  logic rcc_ready,
	output logic [`DMA_DRAM_ADDR_W-1:0] rcc_dram_addr,
	output logic [`DMA_DPRAM_ADDR_W-1:0] rcc_dpram_addr,
	output logic [`DMA_LEN_W-1:0] rcc_length,
	output logic wcc_valid,
	input  logic wcc_ready,
	output logic [`DMA_DRAM_ADDR_W-1:0] wcc_dram_addr,
	output logic [`DMA_DPRAM_ADDR_W-1:0] wcc_dpram_addr,
	output logic [`DMA_LEN_W-1:0] wcc_length,
	output dma_hdr_pkg::dma_word_t wcc_write_data
);

	import dma_hdr_pkg::*;
	import dma_port_pkg::*;

	port_vec_t grant;
	port_id_t grant_id;
	logic burst_done;

	logic burst_push, burst_pop, burst_full, burst_empty;
	dma_word_t burst_in, burst_head;
	logic tag_pop, tag_full, tag_empty;
	port_id_t tag_id;

	logic rcmd_push, rcmd_pop, rcmd_full, rcmd_empty;
	logic wcmd_push, wcmd_pop, wcmd_full, wcmd_empty;
	dma_cmd_t cmd, rcmd_head, wcmd_head;
	logic wdata_push, wdata_pop, wdata_full, wdata_empty;
	dma_word_t wdata_head;

	////////////////////////////////////////////////////////////////////
	// port side

	token_arbiter u_arbiter (
		.fpu_clk(fpu_clk), .reset(reset), .dma_req(dma_req),
		.burst_done(burst_done), .grant(grant), .grant_id(grant_id)
	);

	burst_receiver u_receiver (
		.fpu_clk(fpu_clk), .reset(reset), .grant(grant),
		.dma_write_valid(dma_write_valid), .dma_write_data(dma_write_data),
		.dma_resp(dma_resp), .dma_write_ready(dma_write_ready),
		.burst_full(burst_full || tag_full), .burst_push(burst_push),
		.burst_word(burst_in), .burst_done(burst_done)
	);

	sync_fifo #(.payload_t(dma_word_t), .DEPTH(`DMA_BURST_DEPTH)) u_burst_fifo (
		.fpu_clk(fpu_clk), .reset(reset), .push(burst_push), .wr_data(burst_in),
		.full(burst_full), .pop(burst_pop), .rd_data(burst_head), .empty(burst_empty)
	);

	// id of the port whose burst just finished
	sync_fifo #(.payload_t(port_id_t), .DEPTH(`DMA_TAG_DEPTH)) u_tag_fifo (
		.fpu_clk(fpu_clk), .reset(reset), .push(burst_done), .wr_data(grant_id),
		.full(tag_full), .pop(tag_pop), .rd_data(tag_id), .empty(tag_empty)
	);

	////////////////////////////////////////////////////////////////////
	// command side

	cmd_dispatcher u_dispatcher (
		.fpu_clk(fpu_clk), .reset(reset),
		.burst_empty(burst_empty), .burst_word(burst_head), .burst_pop(burst_pop),
		.tag_empty(tag_empty), .tag_id(tag_id), .tag_pop(tag_pop),
		.rcmd_full(rcmd_full), .rcmd_push(rcmd_push),
		.wcmd_full(wcmd_full), .wcmd_push(wcmd_push), .cmd(cmd),
		.wdata_full(wdata_full), .wdata_push(wdata_push)
	);

	sync_fifo #(.payload_t(dma_cmd_t), .DEPTH(`DMA_CMD_DEPTH)) u_rcmd_fifo (
		.fpu_clk(fpu_clk), .reset(reset), .push(rcmd_push), .wr_data(cmd),
		.full(rcmd_full), .pop(rcmd_pop), .rd_data(rcmd_head), .empty(rcmd_empty)
	);

	sync_fifo #(.payload_t(dma_cmd_t), .DEPTH(`DMA_CMD_DEPTH)) u_wcmd_fifo (
		.fpu_clk(fpu_clk), .reset(reset), .push(wcmd_push), .wr_data(cmd),
		.full(wcmd_full), .pop(wcmd_pop), .rd_data(wcmd_head), .empty(wcmd_empty)
	);

	// write data leaves the burst FIFO head directly
	sync_fifo #(.payload_t(dma_word_t), .DEPTH(`DMA_WDATA_DEPTH)) u_wdata_fifo (
		.fpu_clk(fpu_clk), .reset(reset), .push(wdata_push), .wr_data(burst_head),
		.full(wdata_full), .pop(wdata_pop), .rd_data(wdata_head), .empty(wdata_empty)
	);

	write_cmd_issuer u_issuer (
		.fpu_clk(fpu_clk), .reset(reset),
		.wcmd_empty(wcmd_empty), .wcmd(wcmd_head), .wcmd_pop(wcmd_pop),
		.wdata_empty(wdata_empty), .wdata(wdata_head), .wdata_pop(wdata_pop),
		.wcc_valid(wcc_valid), .wcc_ready(wcc_ready),
		.wcc_dram_addr(wcc_dram_addr), .wcc_dpram_addr(wcc_dpram_addr),
		.wcc_length(wcc_length), .wcc_write_data(wcc_write_data)
	);

	// read commands straight off the FIFO head
	assign rcc_valid = !rcmd_empty;
	assign rcmd_pop = rcc_valid && rcc_ready;
	assign rcc_length = rcmd_head.length;
	assign rcc_dram_addr = rcmd_head.dram_addr;
	assign rcc_dpram_addr = rcmd_head.dpram_addr;

endmodule

/* verilog/dma_port_pkg.sv */
/*
 * Accelerator port identity types.
 * Per-port vectors are indexed by port id.
 */
`include "dma_path_cfg.svh"

package dma_port_pkg;

	typedef logic [$clog2(`DMA_NUM_PORTS)-1:0] port_id_t;
	typedef logic [`DMA_NUM_PORTS-1:0] port_vec_t;    // one bit per port

endpackage

/* verilog/sync_fifo.sv */
/*
 * Single-clock first-word-fall-through FIFO.
 * The head is on rd_data whenever empty is low.
 * Push when full or pop when empty is not allowed and is not guarded.
 * DEPTH must be a power of two.
 */
`timescale 1ns/100ps

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 16
) (
	input  logic fpu_clk,
	input  logic reset,
	input  logic push,
	input  payload_t wr_data,
	output logic full,
	input  logic pop,
	output payload_t rd_data,
	output logic empty
);

	localparam int AW = $clog2(DEPTH);

	payload_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count;     // occupancy, one bit wider than the pointers

	always_ff @(posedge fpu_clk) begin
		if (push) mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1;    // wraps at DEPTH
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop) count <= count + 1'b1;
			else if (pop && !push) count <= count - 1'b1;
		end
	end

	assign rd_data = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == (AW+1)'(DEPTH));

endmodule

/* verilog/token_arbiter.sv */
/*
 * Round-robin DMA token arbiter over the accelerator ports.
 * A grant is held until burst_done; the search then restarts at the port
 * after the one just served. A port that keeps dma_req high after its burst
 * is granted again only when no other port is asking.
 */
`timescale 1ns/100ps
`include "dma_path_cfg.svh"

module token_arbiter (
	input  logic fpu_clk,
	input  logic reset,
	input  dma_port_pkg::port_vec_t dma_req,
	input  logic burst_done,
	output dma_port_pkg::port_vec_t grant,
	output dma_port_pkg::port_id_t grant_id
);

	import dma_port_pkg::*;

	port_id_t ptr;       // first port looked at
	port_id_t cand;
	port_id_t pick;
	logic found;

	// first requester at or after ptr
	always_comb begin
		found = 1'b0;
		pick = ptr;
		cand = ptr;
		for (int i = 0; i < `DMA_NUM_PORTS; i++) begin
			cand = ptr + port_id_t'(i);
			if (!found && dma_req[cand]) begin
				found = 1'b1;
				pick = cand;
			end
		end
	end

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			grant <= '0;
			grant_id <= '0;
			ptr <= '0;
		end else if (|grant) begin
			if (burst_done) begin
				grant <= '0;
				ptr <= grant_id + port_id_t'(1);    // next in turn
			end
		end else if (found) begin
			grant <= port_vec_t'(1) << pick;
			grant_id <= pick;
		end
	end

endmodule

/* verilog/write_cmd_issuer.sv */
/*
 * Sends each write command with its data words to the system side.
 * Command fields stay on the wcc outputs for the whole burst; wcc_valid is
 * high while a data word is waiting. A zero-length command is consumed
 * without any wcc activity.
 */
`timescale 1ns/100ps
`include "dma_path_cfg.svh"

module write_cmd_issuer (
	input  logic fpu_clk,
	input  logic reset,
	input  logic wcmd_empty,
	input  dma_hdr_pkg::dma_cmd_t wcmd,
	output logic wcmd_pop,
	input  logic wdata_empty,
	input  dma_hdr_pkg::dma_word_t wdata,
	output logic wdata_pop,
	output logic wcc_valid,
	input  logic wcc_ready,
	output logic [`DMA_DRAM_ADDR_W-1:0] wcc_dram_addr,
	output logic [`DMA_DPRAM_ADDR_W-1:0] wcc_dpram_addr,
	output logic [`DMA_LEN_W-1:0] wcc_length,
	output dma_hdr_pkg::dma_word_t wcc_write_data
);

	import dma_hdr_pkg::*;

	logic active;
	dma_len_t cnt;      // words accepted so far

	assign wcmd_pop = !active && !wcmd_empty;
	assign wcc_valid = active && !wdata_empty;
	assign wdata_pop = wcc_valid && wcc_ready;
	assign wcc_write_data = wdata;

	always_ff @(posedge fpu_clk) begin
		if (wcmd_pop) begin
			wcc_length <= wcmd.length;
			wcc_dram_addr <= wcmd.dram_addr;
			wcc_dpram_addr <= wcmd.dpram_addr;
		end
	end

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			active <= 1'b0;
			cnt <= '0;
		end else if (wcmd_pop) begin
			active <= (wcmd.length != '0);
			cnt <= '0;
		end else if (wdata_pop) begin
			cnt <= cnt + dma_len_t'(1);
			if (cnt + dma_len_t'(1) == wcc_length) active <= 1'b0;    // last word
		end
	end

endmodule

/* vlog.f */
+incdir+verilog
+incdir+sim
verilog/dma_hdr_pkg.sv
verilog/dma_port_pkg.sv
verilog/sync_fifo.sv
verilog/token_arbiter.sv
verilog/burst_receiver.sv
verilog/cmd_dispatcher.sv
verilog/write_cmd_issuer.sv
verilog/dma_path_top.sv
sim/tb_dma_path.sv
